// File: Bender.yml
package:
  name: rv_core

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rv_core_pkg.sv
      - fetch_port.sv
      - main_controller.sv
      - instr_decoder.sv
      - exec_unit.sv
      - reg_file.sv
      - rv_core_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - rv_core_props.sv
      - tb_rv_core.sv

// File: exec_unit.sv
`timescale 1ns/1ns
`default_nettype none

module exec_unit (
  input  logic               CLK,
  input  logic               resetn,
  input  logic               start,
  input  rv_core_pkg::ctrl_t ctrl,
  input  logic [31:0]        rs1_val,
  input  logic [31:0]        rs2_val,
  input  logic [31:0]        pc,
  output logic [31:0]        result,
  output logic               alu_rdy,
  output logic [31:0]        pc_next
);

  import rv_core_pkg::*;

  logic [31:0] op_b;
  logic [4:0]  shamt;
  logic        is_shift;
  logic        operands_eq;
  logic        taken;

  // shifter state
  logic [31:0] sh_val;
  logic [31:0] sh_src;
  logic [31:0] sh_one;
  logic [4:0]  sh_cnt;
  logic        sh_busy;

  assign op_b        = ctrl.imm_sel ? ctrl.imm : rs2_val;
  assign shamt       = op_b[4:0];
  assign is_shift    = (ctrl.alu_op == ALU_SLL) || (ctrl.alu_op == ALU_SRL);
  assign operands_eq = (rs1_val == rs2_val);

  // first step taken in the start cycle from rs1
  assign sh_src = sh_busy ? sh_val : rs1_val;
  assign sh_one = (ctrl.alu_op == ALU_SLL) ? {sh_src[30:0], 1'b0} : {1'b0, sh_src[31:1]};

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      sh_busy <= 1'b0;
      sh_cnt  <= 5'd0;
    end else if (start && is_shift && (shamt != 5'd0)) begin
      sh_busy <= 1'b1;
      sh_cnt  <= shamt - 5'd1;
    end else if (sh_busy) begin
      // counter at 0 is the ready cycle
      if (sh_cnt == 5'd0) begin
        sh_busy <= 1'b0;
      end else begin
        sh_cnt <= sh_cnt - 5'd1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if ((start && is_shift) || (sh_busy && (sh_cnt != 5'd0))) begin
      sh_val <= sh_one;
    end
  end

  // shift by n ready n cycles after start, 0 ready at once
  assign alu_rdy = !is_shift || (sh_busy ? (sh_cnt == 5'd0) : (shamt == 5'd0));

  always_comb begin
    taken = 1'b0;
    case (ctrl.alu_op)
      ALU_ADD:    result = rs1_val + op_b;
      ALU_SUB:    result = rs1_val - op_b;
      ALU_AND:    result = rs1_val & op_b;
      ALU_OR:     result = rs1_val | op_b;
      ALU_XOR:    result = rs1_val ^ op_b;
      ALU_SLL,
      ALU_SRL:    result = sh_busy ? sh_val : rs1_val;
      ALU_PASS_B: result = op_b;
      ALU_BEQ: begin
        taken  = ctrl.branch && operands_eq;
        result = {31'd0, taken};
      end
      ALU_BNE: begin
        taken  = ctrl.branch && !operands_eq;
        result = {31'd0, taken};
      end
      default:    result = '0;
    endcase
    // link value for jal
    if (ctrl.jump) begin
      result = pc + 32'd4;
    end
  end

  // branch and jal targets share the pc relative adder
  assign pc_next = (ctrl.jump || taken) ? (pc + ctrl.imm) : (pc + 32'd4);

endmodule

`default_nettype wire

// File: fetch_port.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_port (
  input  logic                    CLK,
  input  logic                    resetn,
  input  logic                    fetch_enable,
  input  logic                    new_instr,
  input  logic [31:0]             next_pc,
  input  logic                    imem_rsp_valid,
  input  rv_core_pkg::fetch_rsp_t imem_rsp,
  output logic                    imem_req,
  output logic [31:0]             imem_addr,
  output logic                    fetch_valid,
  output rv_core_pkg::instr_u     instr_fetch
);

  // request in flight, set the cycle after the strobe
  logic outstanding;
  logic launch;
  logic rsp_hit;

  // only one request at a time, none while a word waits
  assign launch = fetch_enable && !outstanding && !imem_req && !fetch_valid;

  // response must belong to the address still held on imem_addr
  // stray answers are dropped
  assign rsp_hit = imem_rsp_valid && outstanding && (imem_rsp.addr == imem_addr);

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      imem_req    <= 1'b0;
      outstanding <= 1'b0;
      fetch_valid <= 1'b0;
    end else begin
      // single cycle strobe
      imem_req <= launch;
      if (imem_req) begin
        outstanding <= 1'b1;
      end else if (rsp_hit) begin
        outstanding <= 1'b0;
      end
      // word held until the controller takes it
      if (rsp_hit) begin
        fetch_valid <= 1'b1;
      end else if (new_instr) begin
        fetch_valid <= 1'b0;
      end
    end
  end

  // address stays put while the request is outstanding
  always_ff @(posedge CLK) begin
    if (launch) begin
      imem_addr <= next_pc;
    end
    if (rsp_hit) begin
      instr_fetch <= imem_rsp.instr;
    end
  end

endmodule

`default_nettype wire

// File: instr_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
  input  rv_core_pkg::instr_u instr,
  input  logic                instr_valid,
  output rv_core_pkg::ctrl_t  ctrl,
  output logic                decoder_stall,
  output logic                branch,
  output logic                jump
);

  import rv_core_pkg::*;

  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // opcode and funct combination supported
  logic legal;

  always_comb begin
    ctrl  = '0;
    legal = 1'b1;
    // opcode sits at the same bits in every view
    case (instr.r.opcode)
      OPC_OP_IMM: begin
        ctrl.rs1     = instr.i.rs1;
        ctrl.rd      = instr.i.rd;
        ctrl.imm     = {{20{instr.i.imm[11]}}, instr.i.imm};
        ctrl.imm_sel = 1'b1;
        ctrl.wr_req  = 1'b1;
        case (instr.i.funct3)
          3'b000: ctrl.alu_op = ALU_ADD;
          3'b001: ctrl.alu_op = ALU_SLL;
          3'b101: ctrl.alu_op = ALU_SRL;
          default: legal = 1'b0;
        endcase
        // srai and junk in the upper shift bits
        if ((instr.i.funct3 != 3'b000) && (instr.i.imm[11:5] != 7'd0)) begin
          legal = 1'b0;
        end
      end
      OPC_OP: begin
        ctrl.rs1    = instr.r.rs1;
        ctrl.rs2    = instr.r.rs2;
        ctrl.rd     = instr.r.rd;
        ctrl.wr_req = 1'b1;
        case ({instr.r.funct7, instr.r.funct3})
          10'b0000000_000: ctrl.alu_op = ALU_ADD;
          10'b0100000_000: ctrl.alu_op = ALU_SUB;
          10'b0000000_001: ctrl.alu_op = ALU_SLL;
          10'b0000000_100: ctrl.alu_op = ALU_XOR;
          10'b0000000_101: ctrl.alu_op = ALU_SRL;
          10'b0000000_110: ctrl.alu_op = ALU_OR;
          10'b0000000_111: ctrl.alu_op = ALU_AND;
          default: legal = 1'b0;
        endcase
      end
      OPC_LUI: begin
        ctrl.rd      = instr.u.rd;
        ctrl.imm     = {instr.u.imm, 12'd0};
        ctrl.imm_sel = 1'b1;
        ctrl.wr_req  = 1'b1;
        ctrl.alu_op  = ALU_PASS_B;
      end
      OPC_JAL: begin
        ctrl.rd     = instr.j.rd;
        ctrl.imm    = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                       instr.j.imm11, instr.j.imm10_1, 1'b0};
        ctrl.wr_req = 1'b1;
        ctrl.jump   = 1'b1;
      end
      OPC_BRANCH: begin
        // rd stays 0, the rd bits hold offset here
        ctrl.rs1    = instr.b.rs1;
        ctrl.rs2    = instr.b.rs2;
        ctrl.imm    = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                       instr.b.imm10_5, instr.b.imm4_1, 1'b0};
        ctrl.branch = 1'b1;
        case (instr.b.funct3)
          3'b000: ctrl.alu_op = ALU_BEQ;
          3'b001: ctrl.alu_op = ALU_BNE;
          default: legal = 1'b0;
        endcase
      end
      default: legal = 1'b0;
    endcase
    // no side effects from a word that is not valid
    if (!instr_valid) begin
      ctrl.wr_req = 1'b0;
      ctrl.branch = 1'b0;
      ctrl.jump   = 1'b0;
    end
  end

  // unsupported word holds execute forever
  assign decoder_stall = instr_valid && !legal;
  assign branch        = ctrl.branch;
  assign jump          = ctrl.jump;

endmodule

`default_nettype wire

// File: main_controller.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_core_cfg.svh"

module main_controller (
  input  logic                CLK,
  input  logic                resetn,
  input  logic                decoder_stall,
  input  logic                we_reg_controller,
  input  logic                fetch_valid,
  input  logic [31:0]         PCmux,
  input  rv_core_pkg::instr_u instr_fetch,
  input  logic                stall_debug,
  input  logic                branch,
  input  logic                jump,
  input  logic                aluRes_rdy,
  output logic [31:0]         PC,
  output logic [31:0]         nextPC,
  output rv_core_pkg::instr_u instr_fetch_exec,
  output logic                fetch_enable,
  output logic                we_reg,
  output logic                fetch_valid_exec,
  output logic                stall_pc,
  output logic                new_instr
);

  import rv_core_pkg::*;

  // instruction kept here after acceptance until it completes
  logic   fetch_valid_buffer;
  instr_u instr_fetch_buffer;

  logic [31:0] pc_reg;
  logic [31:0] next_pc_reg;

  // last accepted instruction has finished
  logic instr_executed;
  logic instr_executed_reg;

  // accept from the fetch port when nothing is buffered
  always_comb begin
    fetch_valid_exec = fetch_valid_buffer;
    instr_fetch_exec = instr_fetch_buffer;
    new_instr        = 1'b0;
    // debug stall only blocks acceptance
    if (fetch_valid && !fetch_valid_buffer && !stall_debug) begin
      fetch_valid_exec = 1'b1;
      instr_fetch_exec = instr_fetch;
      new_instr        = 1'b1;
    end
  end

  // hold the pc while no valid instruction, slow alu or bad opcode
  assign stall_pc = !fetch_valid_exec || !aluRes_rdy || decoder_stall;

  // branches retire as a write to x0, decoder gives rd 0
  assign we_reg = stall_pc ? 1'b0 : (we_reg_controller || branch);

  // done when the valid instruction passes the stall check
  // otherwise keep the previous state
  always_comb begin
    if (fetch_valid_exec) begin
      instr_executed = !stall_pc;
    end else begin
      instr_executed = instr_executed_reg;
    end
  end

  // rises in the completion cycle, next fetch can overlap retire
  assign fetch_enable = instr_executed;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      fetch_valid_buffer <= 1'b0;
      instr_executed_reg <= 1'b1;
    end else begin
      instr_executed_reg <= instr_executed;
      if (instr_executed) begin
        fetch_valid_buffer <= 1'b0;
      end else if (new_instr) begin
        fetch_valid_buffer <= 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    instr_fetch_buffer <= instr_fetch_exec;
  end

  always_comb begin
    // pc moves to the fetched address on acceptance
    PC = new_instr ? next_pc_reg : pc_reg;
    if (branch || jump) begin
      // redirect known only once resolved
      nextPC = (fetch_valid_exec && !stall_pc) ? PCmux : next_pc_reg;
    end else begin
      // sequential, pc plus 4 is ready at acceptance
      nextPC = new_instr ? PCmux : next_pc_reg;
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      pc_reg      <= `RV_RESET_PC;
      next_pc_reg <= `RV_START_PC;
    end else begin
      pc_reg      <= PC;
      next_pc_reg <= nextPC;
    end
  end

endmodule

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_core_cfg.svh"

module reg_file (
  input  logic                 CLK,
  input  logic                 resetn,
  input  logic [4:0]           rs1,
  input  logic [4:0]           rs2,
  input  logic                 we,
  input  logic [4:0]           rd,
  input  logic [31:0]          wdata,
  input  logic [31:0]          pc,
  input  logic [31:0]          pc_next,
  output logic [31:0]          rs1_val,
  output logic [31:0]          rs2_val,
  output logic                 retire_valid,
  output rv_core_pkg::retire_t retire
);

  logic [31:0] regs [0:`RV_NUM_REGS-1];

  // x0 reads as zero whatever the array holds
  assign rs1_val = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
  assign rs2_val = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

  always_ff @(posedge CLK) begin
    if (we && (rd != 5'd0)) begin
      regs[rd] <= wdata;
    end
  end

  // one retire record per completion, a cycle after the write
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= we;
    end
  end

  always_ff @(posedge CLK) begin
    if (we) begin
      retire.pc      <= pc;
      retire.rd      <= rd;
      // x0 and branches report 0
      retire.value   <= (rd == 5'd0) ? 32'd0 : wdata;
      retire.pc_next <= pc_next;
    end
  end

endmodule

`default_nettype wire

// File: rv_core_cfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// pc held during reset, one word below the first fetch
`define RV_RESET_PC 32'hFFFF_FFFC

// address of the very first instruction fetch
`define RV_START_PC 32'h0000_0000

// architectural registers, x0 included
`define RV_NUM_REGS 32

`endif

// File: rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

  // register-register view
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // register-immediate view, shifts use imm[4:0] as shamt
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // upper immediate view
  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  // branch view, offset bits scattered
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  // jal view
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one instruction word, five ways to read it
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    u_fmt_t u;
    b_fmt_t b;
    j_fmt_t j;
  } instr_u;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_PASS_B,
    ALU_BEQ,
    ALU_BNE
  } alu_op_e;

  // decoded control for the instruction in execute
  typedef struct packed {
    alu_op_e     alu_op;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    // operand b taken from imm instead of rs2
    logic        imm_sel;
    logic        wr_req;
    logic        branch;
    logic        jump;
  } ctrl_t;

  typedef struct packed {
    instr_u      instr;
    logic [31:0] addr;
  } fetch_rsp_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [31:0] value;
    logic [31:0] pc_next;
  } retire_t;

endpackage

`default_nettype wire

// File: rv_core_props.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core_props (
  input logic CLK,
  input logic resetn,
  input logic we_reg,
  input logic stall_pc,
  input logic new_instr,
  input logic instr_buffered,
  input logic imem_req,
  input logic req_outstanding
);

  // failures seen so far
  int unsigned fail_count = 0;

  // no register write while the pc is held
  a_no_write_in_stall: assert property (@(posedge CLK) disable iff (!resetn)
    !(we_reg && stall_pc))
    else begin
      $error("register write strobe while stall_pc is high");
      fail_count++;
    end

  // one request in flight at most
  a_single_request: assert property (@(posedge CLK) disable iff (!resetn)
    !(imem_req && req_outstanding))
    else begin
      $error("imem_req while a request is outstanding");
      fail_count++;
    end

  // accept only into an empty buffer
  a_no_accept_buffered: assert property (@(posedge CLK) disable iff (!resetn)
    !(new_instr && instr_buffered))
    else begin
      $error("new_instr while an instruction is buffered");
      fail_count++;
    end

endmodule

// controller instance with the fetch inputs tied off
bind main_controller rv_core_props ctrl_props (
  .CLK             (CLK),
  .resetn          (resetn),
  .we_reg          (we_reg),
  .stall_pc        (stall_pc),
  .new_instr       (new_instr),
  .instr_buffered  (fetch_valid_buffer),
  .imem_req        (1'b0),
  .req_outstanding (1'b0)
);

// fetch port instance with the controller inputs tied off
bind fetch_port rv_core_props fetch_props (
  .CLK             (CLK),
  .resetn          (resetn),
  .we_reg          (1'b0),
  .stall_pc        (1'b0),
  .new_instr       (1'b0),
  .instr_buffered  (1'b0),
  .imem_req        (imem_req),
  .req_outstanding (outstanding)
);

`default_nettype wire

// File: rv_core_top.sv
`timescale 1ns/1ns
`default_nettype none

module rv_core_top (
  input  logic                    CLK,
  input  logic                    resetn,
  input  logic                    stall_debug,
  output logic                    imem_req,
  output logic [31:0]             imem_addr,
  input  logic                    imem_rsp_valid,
  input  rv_core_pkg::fetch_rsp_t imem_rsp,
  output logic                    retire_valid,
  output rv_core_pkg::retire_t    retire
);

  import rv_core_pkg::*;

  logic        fetch_enable;
  logic        new_instr;
  logic        fetch_valid;
  instr_u      instr_fetch;
  instr_u      instr_exec;
  logic        fetch_valid_exec;
  logic [31:0] pc;
  logic [31:0] next_pc;
  logic [31:0] pc_mux;
  logic        we_reg;
  logic        decoder_stall;
  logic        branch;
  logic        jump;
  ctrl_t       ctrl;
  logic [31:0] rs1_val;
  logic [31:0] rs2_val;
  logic [31:0] alu_result;
  logic        alu_rdy;

  // input side
  fetch_port u_fetch (
    .CLK            (CLK),
    .resetn         (resetn),
    .fetch_enable   (fetch_enable),
    .new_instr      (new_instr),
    .next_pc        (next_pc),
    .imem_rsp_valid (imem_rsp_valid),
    .imem_rsp       (imem_rsp),
    .imem_req       (imem_req),
    .imem_addr      (imem_addr),
    .fetch_valid    (fetch_valid),
    .instr_fetch    (instr_fetch)
  );

  main_controller u_ctrl (
    .CLK               (CLK),
    .resetn            (resetn),
    .decoder_stall     (decoder_stall),
    .we_reg_controller (ctrl.wr_req),
    .fetch_valid       (fetch_valid),
    .PCmux             (pc_mux),
    .instr_fetch       (instr_fetch),
    .stall_debug       (stall_debug),
    .branch            (branch),
    .jump              (jump),
    .aluRes_rdy        (alu_rdy),
    .PC                (pc),
    .nextPC            (next_pc),
    .instr_fetch_exec  (instr_exec),
    .fetch_enable      (fetch_enable),
    .we_reg            (we_reg),
    .fetch_valid_exec  (fetch_valid_exec),
    // stall state is internal to the controller here
    .stall_pc          (),
    .new_instr         (new_instr)
  );

  instr_decoder u_dec (
    .instr         (instr_exec),
    .instr_valid   (fetch_valid_exec),
    .ctrl          (ctrl),
    .decoder_stall (decoder_stall),
    .branch        (branch),
    .jump          (jump)
  );

  // shifter loads on acceptance
  exec_unit u_exec (
    .CLK     (CLK),
    .resetn  (resetn),
    .start   (new_instr),
    .ctrl    (ctrl),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .pc      (pc),
    .result  (alu_result),
    .alu_rdy (alu_rdy),
    .pc_next (pc_mux)
  );

  // output side, branches arrive as we with rd 0
  reg_file u_rf (
    .CLK          (CLK),
    .resetn       (resetn),
    .rs1          (ctrl.rs1),
    .rs2          (ctrl.rs2),
    .we           (we_reg),
    .rd           (ctrl.rd),
    .wdata        (alu_result),
    .pc           (pc),
    .pc_next      (next_pc),
    .rs1_val      (rs1_val),
    .rs2_val      (rs2_val),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

endmodule

`default_nettype wire

// File: tb_rv_core.sv
`timescale 1ns/1ns
`default_nettype none
`include "rv_core_cfg.svh"

module tb_rv_core;

  import rv_core_pkg::*;

  localparam int NUM_ENTRIES = 29;
  localparam int END_ADDR    = NUM_ENTRIES * 4;
  // 40 cycles per entry at 40 ns
  localparam int WATCHDOG_NS = NUM_ENTRIES * 40 * 40;

  // one program word and what its retire must show
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] instr;
    logic [4:0]  rd;
    logic [31:0] value;
    logic [31:0] next_pc;
  } tbl_entry_t;

  logic        CLK;
  logic        resetn;
  logic        stall_debug;
  logic        imem_req;
  logic [31:0] imem_addr;
  logic        imem_rsp_valid;
  fetch_rsp_t  imem_rsp;
  logic        retire_valid;
  retire_t     retire;

  tbl_entry_t prog [NUM_ENTRIES];
  int         fill_idx;
  integer     seed;
  int         errors;
  int         retired;
  int         assert_fails;
  logic       done;

  rv_core_top dut0 (
    .CLK            (CLK),
    .resetn         (resetn),
    .stall_debug    (stall_debug),
    .imem_req       (imem_req),
    .imem_addr      (imem_addr),
    .imem_rsp_valid (imem_rsp_valid),
    .imem_rsp       (imem_rsp),
    .retire_valid   (retire_valid),
    .retire         (retire)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // rv32i encoders for the formats in the program
  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    enc_i = {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    enc_r = {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_lui(input logic [19:0] imm, input logic [4:0] rd);
    enc_lui = {imm, rd, 7'b0110111};
  endfunction

  // branch offset in bytes with bit 0 dropped
  function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    enc_b = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_jal(input logic [20:0] off, input logic [4:0] rd);
    enc_jal = {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  task automatic add_entry(input logic [31:0] word, input logic [4:0] rd,
                           input logic [31:0] value, input logic [31:0] next_pc);
    prog[fill_idx] = {fill_idx * 4, word, rd, value, next_pc};
    fill_idx++;
  endtask

  // straight line code where next pc is pc plus 4
  task automatic add_seq(input logic [31:0] word, input logic [4:0] rd,
                         input logic [31:0] value);
    add_entry(word, rd, value, fill_idx * 4 + 4);
  endtask

  task automatic load_program;
    fill_idx = 0;
    // arithmetic
    add_seq(enc_i(12'd5, 5'd0, 3'b000, 5'd1), 5'd1, 32'h0000_0005);
    add_seq(enc_i(12'hFFD, 5'd0, 3'b000, 5'd2), 5'd2, 32'hFFFF_FFFD);
    add_seq(enc_lui(20'h12345, 5'd3), 5'd3, 32'h1234_5000);
    add_seq(enc_i(12'h67B, 5'd3, 3'b000, 5'd3), 5'd3, 32'h1234_567B);
    add_seq(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd4), 5'd4, 32'h0000_0002);
    add_seq(enc_r(7'h20, 5'd1, 5'd2, 3'b000, 5'd5), 5'd5, 32'hFFFF_FFF8);
    add_seq(enc_r(7'h00, 5'd5, 5'd3, 3'b111, 5'd6), 5'd6, 32'h1234_5678);
    add_seq(enc_r(7'h00, 5'd1, 5'd3, 3'b110, 5'd7), 5'd7, 32'h1234_567F);
    add_seq(enc_r(7'h00, 5'd2, 5'd3, 3'b100, 5'd8), 5'd8, 32'hEDCB_A986);
    // shifts by 0, 1 and 31
    add_seq(enc_i(12'd0, 5'd1, 3'b001, 5'd9), 5'd9, 32'h0000_0005);
    add_seq(enc_i(12'd1, 5'd1, 3'b001, 5'd10), 5'd10, 32'h0000_000A);
    add_seq(enc_i(12'd31, 5'd1, 3'b001, 5'd11), 5'd11, 32'h8000_0000);
    add_seq(enc_i(12'd31, 5'd0, 3'b000, 5'd12), 5'd12, 32'h0000_001F);
    add_seq(enc_r(7'h00, 5'd12, 5'd2, 3'b101, 5'd13), 5'd13, 32'h0000_0001);
    add_seq(enc_i(12'd1, 5'd0, 3'b000, 5'd14), 5'd14, 32'h0000_0001);
    add_seq(enc_r(7'h00, 5'd14, 5'd3, 3'b101, 5'd15), 5'd15, 32'h091A_2B3D);
    add_seq(enc_r(7'h00, 5'd0, 5'd3, 3'b101, 5'd16), 5'd16, 32'h1234_567B);
    add_seq(enc_i(12'd4, 5'd2, 3'b101, 5'd17), 5'd17, 32'h0FFF_FFFF);
    // write to x0 and read it back
    add_seq(enc_i(12'd7, 5'd1, 3'b000, 5'd0), 5'd0, 32'h0000_0000);
    add_seq(enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd18), 5'd18, 32'h0000_0005);
    // beq taken over one word
    add_entry(enc_b(13'd8, 5'd9, 5'd1, 3'b000), 5'd0, 32'd0, 32'h0000_0058);
    add_seq(enc_i(12'd99, 5'd0, 3'b000, 5'd19), 5'd19, 32'd99);
    // bne not taken
    add_entry(enc_b(13'd8, 5'd9, 5'd1, 3'b001), 5'd0, 32'd0, 32'h0000_005C);
    // jal over two words with link 0x60
    add_entry(enc_jal(21'd12, 5'd20), 5'd20, 32'h0000_0060, 32'h0000_0068);
    add_seq(enc_i(12'd1, 5'd0, 3'b000, 5'd21), 5'd21, 32'd1);
    add_seq(enc_i(12'd2, 5'd0, 3'b000, 5'd21), 5'd21, 32'd2);
    add_seq(enc_r(7'h00, 5'd18, 5'd20, 3'b000, 5'd22), 5'd22, 32'h0000_0065);
    add_seq(enc_r(7'h00, 5'd14, 5'd1, 3'b001, 5'd23), 5'd23, 32'h0000_000A);
    add_seq(enc_i(12'd1, 5'd2, 3'b000, 5'd24), 5'd24, 32'hFFFF_FFFE);
  endtask

  task automatic flag_mismatch(input string what, input logic [31:0] exp,
                               input logic [31:0] got);
    errors++;
    $display("CHECK FAILED at %0t ns: %s expected %08h got %08h", $time, what, exp, got);
  endtask

  // instruction memory answers each request after 1 to 6 cycles
  initial begin : imem_model
    int          lat;
    logic [31:0] addr;
    logic        first_req;
    fetch_rsp_t  rsp;
    first_req = 1'b1;
    forever begin
      @(posedge CLK);
      imem_rsp_valid <= 1'b0;
      if (resetn && imem_req === 1'b1) begin
        addr = imem_addr;
        if (first_req && addr !== `RV_START_PC) begin
          flag_mismatch("first fetch address", `RV_START_PC, addr);
        end
        first_req = 1'b0;
        lat = 1 + ($unsigned($random(seed)) % 6);
        repeat (lat - 1) @(posedge CLK);
        // word 0 past the program is an illegal opcode and halts the core
        rsp.addr  = addr;
        rsp.instr = (addr < END_ADDR) ? prog[addr[31:2]].instr : 32'h0;
        imem_rsp_valid <= 1'b1;
        imem_rsp       <= rsp;
      end
    end
  end

  // debug stall stretches at random points
  initial begin : debug_stall_gen
    int gap;
    int len;
    wait (resetn === 1'b1);
    @(posedge CLK);
    while (!done) begin
      gap = $unsigned($random(seed)) % 16;
      repeat (gap) @(posedge CLK);
      len = 1 + ($unsigned($random(seed)) % 8);
      stall_debug <= 1'b1;
      repeat (len) @(posedge CLK);
      stall_debug <= 1'b0;
      @(posedge CLK);
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: retirement stalled after %0d retires", retired);
    $display("** FAIL **");
    $finish;
  end

  initial begin : main_seq
    logic [31:0] exp_pc;
    int          idx;
    int          errs_before;
    seed           = 83;
    errors         = 0;
    retired        = 0;
    done           = 1'b0;
    resetn         = 1'b0;
    stall_debug    = 1'b0;
    imem_rsp_valid = 1'b0;
    imem_rsp       = '0;
    load_program();
    repeat (5) @(posedge CLK);
    resetn <= 1'b1;
    // walk the table along the expected next pc chain
    exp_pc = `RV_START_PC;
    while (exp_pc < END_ADDR) begin
      idx = exp_pc[31:2];
      @(posedge CLK);
      while (retire_valid !== 1'b1) @(posedge CLK);
      retired++;
      errs_before = errors;
      if (retire.pc !== prog[idx].addr) begin
        flag_mismatch("retire pc", prog[idx].addr, retire.pc);
      end
      if (retire.rd !== prog[idx].rd) begin
        flag_mismatch("retire rd", {27'd0, prog[idx].rd}, {27'd0, retire.rd});
      end
      if (retire.value !== prog[idx].value) begin
        flag_mismatch("retire value", prog[idx].value, retire.value);
      end
      if (retire.pc_next !== prog[idx].next_pc) begin
        flag_mismatch("retire next pc", prog[idx].next_pc, retire.pc_next);
      end
      if (errors == errs_before) begin
        $display("retire %0d pc %08h x%0d = %08h ok", retired, exp_pc, prog[idx].rd,
                 prog[idx].value);
      end else begin
        $display("retire %0d pc %08h wrong", retired, exp_pc);
      end
      exp_pc = prog[idx].next_pc;
    end
    done = 1'b1;
    // core must stay quiet on the illegal word past the end
    repeat (40) begin
      @(posedge CLK);
      if (retire_valid === 1'b1) begin
        errors++;
        $display("unexpected retire after the end of the program at pc %08h", retire.pc);
      end
    end
    assert_fails = dut0.u_ctrl.ctrl_props.fail_count + dut0.u_fetch.fetch_props.fail_count;
    $display("retired %0d, failed checks %0d, assertion failures %0d", retired, errors,
             assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+.
rv_core_pkg.sv
fetch_port.sv
main_controller.sv
instr_decoder.sv
exec_unit.sv
reg_file.sv
rv_core_top.sv
rv_core_props.sv
tb_rv_core.sv
